// ==== bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    // byte address as seen on cbus, no translation
    typedef logic [31:0] addr_t;

    // one bus word
    typedef logic [31:0] word_t;

    // byte enables, all zero means read
    typedef logic [3:0] strobe_t;

    // fetch response, first beat in the low half
    typedef logic [63:0] line_t;

    // requester index
    typedef logic [1:0] port_t;

    // cbus burst length, beats minus one
    typedef logic [3:0] len_t;

    // number of core-side requesters
    localparam int NUM_PORTS = 3;

    // port indices, listed from highest to lowest priority
    localparam port_t PORT_D1 = 2'd2;
    localparam port_t PORT_D0 = 2'd1;
    localparam port_t PORT_I  = 2'd0;

    // cbus master FSM
    typedef enum logic [1:0] {
        S_IDLE = 2'd0,
        S_SEND = 2'd1,
        S_DONE = 2'd2
    } cbus_state_t;

endpackage

`default_nettype wire

// ==== bus_req_latch.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_req_latch #(
    parameter bit PORT_IS_FETCH = 1'b0
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             valid,
    input  bus_pkg::addr_t   addr,
    input  bus_pkg::strobe_t strobe,
    input  bus_pkg::word_t   wdata,
    output logic             addr_ok,
    input  logic             done,
    input  bus_pkg::line_t   rsp_data,
    output logic             data_ok,
    output bus_pkg::line_t   rdata,
    output logic             pending,
    output bus_pkg::addr_t   req_addr,
    output bus_pkg::strobe_t req_strobe,
    output bus_pkg::word_t   req_wdata
);
    import bus_pkg::*;

    logic    accept;
    addr_t   addr_q;
    strobe_t strobe_q;
    word_t   wdata_q;

    // one slot, so the core may hand over only while it is empty
    assign addr_ok = ~pending;
    assign accept  = valid & addr_ok;

    // accept and done never meet: done needs pending, accept needs it low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (accept) begin
            pending <= 1'b1;
        end else if (done) begin
            pending <= 1'b0;
        end
    end

    // request fields, captured at the handshake edge
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q   <= addr;
            strobe_q <= strobe;
            wdata_q  <= wdata;
        end
    end

    assign req_addr = addr_q;

    // fetches are always reads
    assign req_strobe = PORT_IS_FETCH ? strobe_t'(0) : strobe_q;
    assign req_wdata  = PORT_IS_FETCH ? word_t'(0) : wdata_q;

    // completion goes straight back, same cycle as done
    assign data_ok = done;
    // data ports only look at the low word
    assign rdata   = rsp_data;

    // master must only finish a request this latch is holding
    assert property (@(posedge clk) disable iff (!rst_n) done |-> pending)
        else $error("done pulse on an empty request latch");

endmodule

`default_nettype wire

// ==== bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  logic [bus_pkg::NUM_PORTS-1:0] pending,
    input  logic                          busy,
    output bus_pkg::port_t                grant,
    output logic                          grant_valid
);
    import bus_pkg::*;

    // priority runs older data slot, younger data slot, fetch
    // keeps the dual-issue pair in program order on the bus
    always_comb begin
        grant       = PORT_D1;
        grant_valid = 1'b0;
        // one transaction at a time on cbus
        if (!busy) begin
            if (pending[PORT_D1]) begin
                grant       = PORT_D1;
                grant_valid = 1'b1;
            end else if (pending[PORT_D0]) begin
                grant       = PORT_D0;
                grant_valid = 1'b1;
            end else if (pending[PORT_I]) begin
                grant       = PORT_I;
                grant_valid = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== cbus_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module cbus_master #(
    parameter int IFETCH_BEATS = 2
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  bus_pkg::port_t                            grant,
    input  logic                                      grant_valid,
    input  bus_pkg::addr_t   [bus_pkg::NUM_PORTS-1:0] req_addr,
    input  bus_pkg::strobe_t [bus_pkg::NUM_PORTS-1:0] req_strobe,
    input  bus_pkg::word_t   [bus_pkg::NUM_PORTS-1:0] req_wdata,
    output logic                                      busy,
    output logic             [bus_pkg::NUM_PORTS-1:0] done,
    output bus_pkg::line_t                            rsp_data,
    output logic                                      creq_valid,
    output logic                                      creq_is_write,
    output bus_pkg::addr_t                            creq_addr,
    output bus_pkg::len_t                             creq_len,
    output bus_pkg::strobe_t                          creq_strobe,
    output bus_pkg::word_t                            creq_data,
    input  logic                                      cresp_ready,
    input  logic                                      cresp_last,
    input  bus_pkg::word_t                            cresp_data
);
    import bus_pkg::*;

    // fetch burst length in beats minus one
    // line_t holds at most two beats
    localparam len_t FETCH_LEN = len_t'(IFETCH_BEATS - 1);

    cbus_state_t state;
    port_t       port_q;
    len_t        beat_cnt;
    logic        start;
    logic        beat;

    assign start = (state == S_IDLE) & grant_valid;

    // one beat per cycle with valid and ready both high
    assign beat = creq_valid & cresp_ready;

    // valid comes straight off the state register
    assign creq_valid = (state == S_SEND);
    // also covers the done cycle while the latch still shows pending
    assign busy       = (state != S_IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (grant_valid) begin
                        state    <= S_SEND;
                        beat_cnt <= '0;
                    end
                end
                S_SEND: begin
                    // ready low just stretches the beat
                    if (beat) begin
                        beat_cnt <= beat_cnt + len_t'(1);
                        if (cresp_last) begin
                            state <= S_DONE;
                        end
                    end
                end
                S_DONE: begin
                    state <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // request fields frozen from capture to the final beat
    always_ff @(posedge clk) begin
        if (start) begin
            port_q        <= grant;
            creq_addr     <= req_addr[grant];
            creq_strobe   <= req_strobe[grant];
            creq_data     <= req_wdata[grant];
            // nonzero strobe means write
            creq_is_write <= |req_strobe[grant];
            creq_len      <= (grant == PORT_I) ? FETCH_LEN : len_t'(0);
            // single-beat reads leave the high word zero
            rsp_data      <= '0;
        end else if (beat && !creq_is_write) begin
            // beat 0 fills the low word and beat 1 the high word
            if (beat_cnt[0]) begin
                rsp_data[63:32] <= cresp_data;
            end else begin
                rsp_data[31:0] <= cresp_data;
            end
        end
    end

    // completion pulse only to the port that owned the transaction
    always_comb begin
        done = '0;
        if (state == S_DONE) begin
            done[port_q] = 1'b1;
        end
    end

    // memory ends the burst exactly on beat len
    assert property (@(posedge clk) disable iff (!rst_n)
        beat && cresp_last |-> beat_cnt == creq_len)
        else $error("cresp_last on beat %0d, len %0d", beat_cnt, creq_len);

endmodule

`default_nettype wire

// ==== core_mem_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_mem_bridge #(
    parameter int IFETCH_BEATS = 2
) (
    input  logic             clk,
    input  logic             rst_n,
    // instruction port
    input  logic             ireq_valid,
    input  bus_pkg::addr_t   ireq_addr,
    output logic             iresp_addr_ok,
    output logic             iresp_data_ok,
    output bus_pkg::line_t   iresp_rdata,
    // data port 1, older of the pair
    input  logic             dreq1_valid,
    input  bus_pkg::addr_t   dreq1_addr,
    input  bus_pkg::strobe_t dreq1_strobe,
    input  bus_pkg::word_t   dreq1_wdata,
    output logic             dresp1_addr_ok,
    output logic             dresp1_data_ok,
    output bus_pkg::word_t   dresp1_rdata,
    // data port 0, younger of the pair
    input  logic             dreq0_valid,
    input  bus_pkg::addr_t   dreq0_addr,
    input  bus_pkg::strobe_t dreq0_strobe,
    input  bus_pkg::word_t   dreq0_wdata,
    output logic             dresp0_addr_ok,
    output logic             dresp0_data_ok,
    output bus_pkg::word_t   dresp0_rdata,
    // cbus
    output logic             creq_valid,
    output logic             creq_is_write,
    output bus_pkg::addr_t   creq_addr,
    output bus_pkg::len_t    creq_len,
    output bus_pkg::strobe_t creq_strobe,
    output bus_pkg::word_t   creq_data,
    input  logic             cresp_ready,
    input  logic             cresp_last,
    input  bus_pkg::word_t   cresp_data
);
    import bus_pkg::*;

    logic    [NUM_PORTS-1:0] pending;
    logic    [NUM_PORTS-1:0] done;
    addr_t   [NUM_PORTS-1:0] req_addr;
    strobe_t [NUM_PORTS-1:0] req_strobe;
    word_t   [NUM_PORTS-1:0] req_wdata;
    port_t                   grant;
    logic                    grant_valid;
    logic                    busy;
    line_t                   rsp_data;
    line_t                   d1_rdata;
    line_t                   d0_rdata;

    // data ports return one word
    assign dresp1_rdata = d1_rdata[31:0];
    assign dresp0_rdata = d0_rdata[31:0];

    bus_req_latch #(.PORT_IS_FETCH(1'b0)) u_latch_d1 (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid      (dreq1_valid),
        .addr       (dreq1_addr),
        .strobe     (dreq1_strobe),
        .wdata      (dreq1_wdata),
        .addr_ok    (dresp1_addr_ok),
        .done       (done[PORT_D1]),
        .rsp_data   (rsp_data),
        .data_ok    (dresp1_data_ok),
        .rdata      (d1_rdata),
        .pending    (pending[PORT_D1]),
        .req_addr   (req_addr[PORT_D1]),
        .req_strobe (req_strobe[PORT_D1]),
        .req_wdata  (req_wdata[PORT_D1])
    );

    bus_req_latch #(.PORT_IS_FETCH(1'b0)) u_latch_d0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid      (dreq0_valid),
        .addr       (dreq0_addr),
        .strobe     (dreq0_strobe),
        .wdata      (dreq0_wdata),
        .addr_ok    (dresp0_addr_ok),
        .done       (done[PORT_D0]),
        .rsp_data   (rsp_data),
        .data_ok    (dresp0_data_ok),
        .rdata      (d0_rdata),
        .pending    (pending[PORT_D0]),
        .req_addr   (req_addr[PORT_D0]),
        .req_strobe (req_strobe[PORT_D0]),
        .req_wdata  (req_wdata[PORT_D0])
    );

    // fetch port has no write side
    bus_req_latch #(.PORT_IS_FETCH(1'b1)) u_latch_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid      (ireq_valid),
        .addr       (ireq_addr),
        .strobe     (strobe_t'(0)),
        .wdata      (word_t'(0)),
        .addr_ok    (iresp_addr_ok),
        .done       (done[PORT_I]),
        .rsp_data   (rsp_data),
        .data_ok    (iresp_data_ok),
        .rdata      (iresp_rdata),
        .pending    (pending[PORT_I]),
        .req_addr   (req_addr[PORT_I]),
        .req_strobe (req_strobe[PORT_I]),
        .req_wdata  (req_wdata[PORT_I])
    );

    bus_arbiter u_arbiter (
        .pending     (pending),
        .busy        (busy),
        .grant       (grant),
        .grant_valid (grant_valid)
    );

    cbus_master #(.IFETCH_BEATS(IFETCH_BEATS)) u_master (
        .clk           (clk),
        .rst_n         (rst_n),
        .grant         (grant),
        .grant_valid   (grant_valid),
        .req_addr      (req_addr),
        .req_strobe    (req_strobe),
        .req_wdata     (req_wdata),
        .busy          (busy),
        .done          (done),
        .rsp_data      (rsp_data),
        .creq_valid    (creq_valid),
        .creq_is_write (creq_is_write),
        .creq_addr     (creq_addr),
        .creq_len      (creq_len),
        .creq_strobe   (creq_strobe),
        .creq_data     (creq_data),
        .cresp_ready   (cresp_ready),
        .cresp_last    (cresp_last),
        .cresp_data    (cresp_data)
    );

endmodule

`default_nettype wire

// ==== tb_core_mem_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_core_mem_bridge;
    import bus_pkg::*;

    localparam int IFETCH_BEATS = 2;

    // one table row with request fields, start group and expected read data
    typedef struct packed {
        port_t   port;
        addr_t   addr;
        strobe_t strobe;
        word_t   wdata;
        int      group;
        line_t   exp;
    } stim_t;

    logic clk;
    logic rst_n;
    logic ireq_valid, iresp_addr_ok, iresp_data_ok;
    addr_t ireq_addr;
    line_t iresp_rdata;
    logic dreq1_valid, dresp1_addr_ok, dresp1_data_ok;
    addr_t dreq1_addr;
    strobe_t dreq1_strobe;
    word_t dreq1_wdata, dresp1_rdata;
    logic dreq0_valid, dresp0_addr_ok, dresp0_data_ok;
    addr_t dreq0_addr;
    strobe_t dreq0_strobe;
    word_t dreq0_wdata, dresp0_rdata;
    logic creq_valid, creq_is_write;
    addr_t creq_addr;
    len_t creq_len;
    strobe_t creq_strobe;
    word_t creq_data;
    logic cresp_ready, cresp_last;
    word_t cresp_data;

    // bit index matches the port constants
    logic [NUM_PORTS-1:0] valid_vec, addr_ok_vec, data_ok_vec;
    assign valid_vec   = {dreq1_valid, dreq0_valid, ireq_valid};
    assign addr_ok_vec = {dresp1_addr_ok, dresp0_addr_ok, iresp_addr_ok};
    assign data_ok_vec = {dresp1_data_ok, dresp0_data_ok, iresp_data_ok};

    stim_t stim[$];
    int    cbus_order[$];
    int    order_by_port[NUM_PORTS][$];
    int    last_group;
    logic  table_ready = 1'b0;

    // memory model array and the separate expected-value shadow
    word_t mem_words[addr_t];
    word_t shadow_words[addr_t];

    // memory model state sampled on the falling edge
    logic        s_valid = 1'b0;
    logic        s_end = 1'b0;
    addr_t       s_addr = '0;
    len_t        s_len = '0;
    len_t        beat_no = '0;
    logic [31:0] rnd_state = 32'd95335;

    // previous cbus cycle for the stall check
    logic    p_valid = 1'b0;
    logic    p_ready = 1'b0;
    logic    p_is_write;
    addr_t   p_addr;
    len_t    p_len;
    strobe_t p_strobe;
    word_t   p_data;

    core_mem_bridge #(.IFETCH_BEATS(IFETCH_BEATS)) u_core_mem_bridge (
        .clk(clk), .rst_n(rst_n),
        .ireq_valid(ireq_valid), .ireq_addr(ireq_addr),
        .iresp_addr_ok(iresp_addr_ok), .iresp_data_ok(iresp_data_ok),
        .iresp_rdata(iresp_rdata),
        .dreq1_valid(dreq1_valid), .dreq1_addr(dreq1_addr),
        .dreq1_strobe(dreq1_strobe), .dreq1_wdata(dreq1_wdata),
        .dresp1_addr_ok(dresp1_addr_ok), .dresp1_data_ok(dresp1_data_ok),
        .dresp1_rdata(dresp1_rdata),
        .dreq0_valid(dreq0_valid), .dreq0_addr(dreq0_addr),
        .dreq0_strobe(dreq0_strobe), .dreq0_wdata(dreq0_wdata),
        .dresp0_addr_ok(dresp0_addr_ok), .dresp0_data_ok(dresp0_data_ok),
        .dresp0_rdata(dresp0_rdata),
        .creq_valid(creq_valid), .creq_is_write(creq_is_write),
        .creq_addr(creq_addr), .creq_len(creq_len),
        .creq_strobe(creq_strobe), .creq_data(creq_data),
        .cresp_ready(cresp_ready), .cresp_last(cresp_last),
        .cresp_data(cresp_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(string line);
        $display("%s", line);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(string msg);
        abort_run($sformatf("FAIL @ %0d ns: %s", $time, msg));
    endtask

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic addr_t word_key(addr_t a);
        return {a[31:2], 2'b00};
    endfunction

    // initial memory contents
    function automatic word_t rule_word(addr_t a);
        return word_key(a) ^ 32'hA5A5_0000;
    endfunction

    function automatic word_t merge_bytes(word_t old_w, word_t new_w, strobe_t s);
        word_t r;
        int    b;
        r = old_w;
        for (b = 0; b < 4; b++) begin
            if (s[b]) begin
                r[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return r;
    endfunction

    function automatic word_t mem_word(addr_t a);
        if (mem_words.exists(word_key(a))) begin
            return mem_words[word_key(a)];
        end
        return rule_word(a);
    endfunction

    function automatic word_t expect_word(addr_t a);
        if (shadow_words.exists(word_key(a))) begin
            return shadow_words[word_key(a)];
        end
        return rule_word(a);
    endfunction

    task automatic add_entry(port_t port, addr_t addr, strobe_t strobe, word_t wdata, int group);
        stim_t e;
        e.port   = port;
        e.addr   = addr;
        e.strobe = strobe;
        e.wdata  = wdata;
        e.group  = group;
        e.exp    = '0;
        stim.push_back(e);
    endtask

    task automatic load_table();
        // plain fetch
        add_entry(PORT_I,  32'h0000_1000, 4'b0000, 32'h0000_0000, 0);
        // partial write then read back on the other data port
        add_entry(PORT_D1, 32'h0000_2040, 4'b0101, 32'h1122_3344, 1);
        add_entry(PORT_D0, 32'h0000_2040, 4'b0000, 32'h0000_0000, 2);
        // all three at once with cbus order D1, D0, I
        add_entry(PORT_I,  32'h0000_1008, 4'b0000, 32'h0000_0000, 3);
        add_entry(PORT_D0, 32'h3000_0020, 4'b1111, 32'hDEAD_BEEF, 3);
        add_entry(PORT_D1, 32'h3000_0010, 4'b0000, 32'h0000_0000, 3);
        // back to back fetches each raised in the previous data_ok cycle
        add_entry(PORT_I,  32'h0000_2040, 4'b0000, 32'h0000_0000, 4);
        add_entry(PORT_I,  32'h3000_0020, 4'b0000, 32'h0000_0000, 5);
        // older write wins over younger read of the same word
        add_entry(PORT_D0, 32'h0000_1004, 4'b0000, 32'h0000_0000, 6);
        add_entry(PORT_D1, 32'h0000_1004, 4'b1000, 32'hAB00_0000, 6);
        // older read sees the value before the younger write
        add_entry(PORT_D0, 32'h4000_0000, 4'b0011, 32'h0000_5A5A, 7);
        add_entry(PORT_D1, 32'h4000_0000, 4'b0000, 32'h0000_0000, 7);
        add_entry(PORT_I,  32'h0000_1000, 4'b0000, 32'h0000_0000, 8);
        add_entry(PORT_D0, 32'h4000_0000, 4'b0000, 32'h0000_0000, 9);
    endtask

    // walk the table in group then arbiter priority order
    task automatic build_expected();
        port_t prio[NUM_PORTS];
        stim_t e;
        word_t hi;
        int    g;
        int    k;
        int    i;
        prio = '{PORT_D1, PORT_D0, PORT_I};
        last_group = 0;
        for (i = 0; i < stim.size(); i++) begin
            if (stim[i].group > last_group) begin
                last_group = stim[i].group;
            end
        end
        for (g = 0; g <= last_group; g++) begin
            for (k = 0; k < NUM_PORTS; k++) begin
                for (i = 0; i < stim.size(); i++) begin
                    if (stim[i].group == g && stim[i].port == prio[k]) begin
                        e = stim[i];
                        cbus_order.push_back(i);
                        order_by_port[prio[k]].push_back(i);
                        if (e.strobe != '0) begin
                            shadow_words[word_key(e.addr)] =
                                merge_bytes(expect_word(e.addr), e.wdata, e.strobe);
                        end else if (e.port == PORT_I) begin
                            hi = (IFETCH_BEATS > 1) ? expect_word(e.addr + 32'd4) : '0;
                            e.exp = {hi, expect_word(e.addr)};
                        end else begin
                            e.exp = {32'h0, expect_word(e.addr)};
                        end
                        stim[i] = e;
                    end
                end
            end
        end
    endtask

    function automatic int group_size(int g);
        int n;
        int i;
        n = 0;
        for (i = 0; i < stim.size(); i++) begin
            if (stim[i].group == g) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic drive_port(stim_t e);
        case (e.port)
            PORT_D1: begin
                dreq1_valid  <= 1'b1;
                dreq1_addr   <= e.addr;
                dreq1_strobe <= e.strobe;
                dreq1_wdata  <= e.wdata;
            end
            PORT_D0: begin
                dreq0_valid  <= 1'b1;
                dreq0_addr   <= e.addr;
                dreq0_strobe <= e.strobe;
                dreq0_wdata  <= e.wdata;
            end
            default: begin
                ireq_valid <= 1'b1;
                ireq_addr  <= e.addr;
            end
        endcase
    endtask

    // drop valid on ports whose handshake happened at this edge
    task automatic release_accepted(logic [NUM_PORTS-1:0] drop);
        if (drop[PORT_D1]) dreq1_valid <= 1'b0;
        if (drop[PORT_D0]) dreq0_valid <= 1'b0;
        if (drop[PORT_I]) ireq_valid <= 1'b0;
    endtask

    task automatic check_cbus_request(int idx);
        stim_t e;
        len_t  exp_len;
        e = stim[idx];
        exp_len = (e.port == PORT_I) ? len_t'(IFETCH_BEATS - 1) : len_t'(0);
        assert (creq_addr == e.addr)
            else report_mismatch($sformatf("cbus addr %h, expected %h", creq_addr, e.addr));
        assert (creq_len == exp_len && creq_is_write == (e.strobe != '0)
                && creq_strobe == e.strobe)
            else report_mismatch($sformatf("cbus len/write/strobe %0d/%b/%b at %h",
                creq_len, creq_is_write, creq_strobe, creq_addr));
        if (e.strobe != '0) begin
            assert (creq_data == e.wdata)
                else report_mismatch($sformatf("cbus write data %h, expected %h",
                    creq_data, e.wdata));
        end
    endtask

    function automatic line_t rdata_of(port_t p);
        if (p == PORT_D1) return {32'h0, dresp1_rdata};
        if (p == PORT_D0) return {32'h0, dresp0_rdata};
        return iresp_rdata;
    endfunction

    // cbus monitor and memory model bookkeeping on the falling edge
    always @(negedge clk) begin : cbus_monitor
        int    idx;
        int    p;
        port_t pt;
        if (rst_n) begin
            // a stalled request must not move
            if (p_valid && !p_ready) begin
                assert (creq_valid && creq_addr == p_addr && creq_len == p_len
                        && creq_is_write == p_is_write && creq_strobe == p_strobe
                        && creq_data == p_data)
                    else report_mismatch("cbus request changed while ready was low");
            end
            if (creq_valid && !p_valid) begin
                assert (cbus_order.size() != 0)
                    else abort_run("a cbus transaction started with no request left to serve");
                idx = cbus_order.pop_front();
                check_cbus_request(idx);
            end
            s_end = 1'b0;
            if (creq_valid && cresp_ready) begin
                if (creq_is_write) begin
                    mem_words[word_key(creq_addr)] =
                        merge_bytes(mem_word(creq_addr), creq_data, creq_strobe);
                end
                if (cresp_last) begin
                    beat_no = '0;
                    s_end   = 1'b1;
                end else begin
                    beat_no = beat_no + len_t'(1);
                end
            end
            for (p = 0; p < NUM_PORTS; p++) begin
                pt = port_t'(p);
                if (data_ok_vec[p]) begin
                    assert (order_by_port[p].size() != 0)
                        else abort_run($sformatf("port %0d answered a request it never got", p));
                    idx = order_by_port[p].pop_front();
                    if (stim[idx].strobe == '0) begin
                        assert (rdata_of(pt) == stim[idx].exp)
                            else report_mismatch($sformatf("port %0d read %h at %h, expected %h",
                                p, rdata_of(pt), stim[idx].addr, stim[idx].exp));
                    end
                end
            end
            s_valid    = creq_valid;
            s_addr     = creq_addr;
            s_len      = creq_len;
            p_valid    = creq_valid;
            p_ready    = cresp_ready;
            p_addr     = creq_addr;
            p_len      = creq_len;
            p_is_write = creq_is_write;
            p_strobe   = creq_strobe;
            p_data     = creq_data;
        end
    end

    // cbus memory with ready low about one cycle in three
    always @(posedge clk) begin : cbus_memory
        if (s_valid && !s_end) begin
            rnd_state = xorshift(rnd_state);
            cresp_ready <= (rnd_state % 32'd3) != 32'd0;
            cresp_last  <= beat_no == s_len;
            cresp_data  <= mem_word(s_addr + (addr_t'(beat_no) << 2));
        end else begin
            cresp_ready <= 1'b0;
            cresp_last  <= 1'b0;
        end
    end

    initial begin : watchdog
        wait (table_ready);
        repeat (stim.size() * 40) @(posedge clk);
        abort_run("timeout: the bridge stopped making progress before the table was done");
    end

    initial begin : stimulus
        int                   g;
        int                   i;
        int                   issued;
        int                   completed;
        logic [NUM_PORTS-1:0] drop;
        logic                 go_next;
        logic                 last_beat;
        rst_n        = 1'b0;
        ireq_valid   = 1'b0;
        ireq_addr    = '0;
        dreq1_valid  = 1'b0;
        dreq1_addr   = '0;
        dreq1_strobe = '0;
        dreq1_wdata  = '0;
        dreq0_valid  = 1'b0;
        dreq0_addr   = '0;
        dreq0_strobe = '0;
        dreq0_wdata  = '0;
        cresp_ready  = 1'b0;
        cresp_last   = 1'b0;
        cresp_data   = '0;
        load_table();
        build_expected();
        table_ready = 1'b1;
        issued    = 0;
        completed = 0;
        drop      = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!creq_valid && data_ok_vec == '0 && addr_ok_vec == '1)
            else report_mismatch("outputs not idle after reset");
        for (g = 0; g <= last_group; g++) begin
            @(posedge clk);
            release_accepted(drop);
            for (i = 0; i < stim.size(); i++) begin
                if (stim[i].group == g) begin
                    drive_port(stim[i]);
                    issued++;
                end
            end
            go_next = 1'b0;
            while (!go_next) begin
                @(negedge clk);
                completed += $countones(data_ok_vec);
                drop      = valid_vec & addr_ok_vec;
                last_beat = creq_valid & cresp_ready & cresp_last;
                if (completed == issued) begin
                    go_next = 1'b1;
                end else if (g < last_group && group_size(g + 1) == 1 && last_beat
                             && completed + 1 == issued) begin
                    // single next request goes out in the data_ok cycle
                    go_next = 1'b1;
                end
                if (!go_next) begin
                    @(posedge clk);
                    release_accepted(drop);
                end
            end
        end
        @(posedge clk);
        release_accepted(drop);
        assert (cbus_order.size() == 0 && order_by_port[0].size() == 0
                && order_by_port[1].size() == 0 && order_by_port[2].size() == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            abort_run("some requests never reached cbus or never got a response");
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
bus_pkg.sv
bus_req_latch.sv
bus_arbiter.sv
cbus_master.sv
core_mem_bridge.sv
tb_core_mem_bridge.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f project.f \
    --top-module tb_core_mem_bridge \
    --Mdir obj_dir \
    -o sim_core_mem_bridge
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit "$build_status"
fi

./obj_dir/sim_core_mem_bridge
run_status=$?
if [ "$run_status" -ne 0 ]; then
    echo "simulation failed with status $run_status"
    exit "$run_status"
fi

exit 0
